// File: rtl/mem_port_pkg.sv
// ----------------------------------------------------------------------
// shared widths and channel structs of the memory port multiplexer
// requester class is ID[3:2] and W_FIFO_DEPTH must be a power of two
// ----------------------------------------------------------------------

package mem_port_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------
  localparam int ADDR_W       = 32;
  localparam int DATA_W       = 64;
  localparam int STRB_W       = DATA_W / 8;
  localparam int ID_W         = 4;
  localparam int NUM_SRC      = 3;
  localparam int SRC_W        = 2;              // width of a requester index
  localparam int W_FIFO_DEPTH = 4;              // outstanding writes
  localparam int W_PTR_W      = $clog2(W_FIFO_DEPTH);

  // ----------------------------------------------------------------------
  // ID class encoding
  // ----------------------------------------------------------------------
  localparam logic [ID_W-1:0] ID_FETCH        = 4'b0000;
  localparam logic [ID_W-1:0] ID_DATA         = 4'b1100;
  localparam logic [1:0]      ID_CLASS_BYPASS = 2'b10;  // low bits free
  localparam logic [1:0]      ID_CLASS_DATA   = 2'b11;

  typedef enum logic [SRC_W-1:0] {
    SRC_FETCH  = 2'd0,
    SRC_BYPASS = 2'd1,
    SRC_DATA   = 2'd2
  } src_e;

  // ----------------------------------------------------------------------
  // channel payloads
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
  } mem_ar_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
  } mem_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } mem_w_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    logic              last;
  } mem_r_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } mem_b_t;

  // requester towards memory
  typedef struct packed {
    mem_ar_t ar;
    logic    ar_valid;
    mem_aw_t aw;
    logic    aw_valid;
    mem_w_t  w;
    logic    w_valid;
    logic    r_ready;
    logic    b_ready;
  } mem_req_t;

  // memory towards requester
  typedef struct packed {
    logic    ar_ready;
    logic    aw_ready;
    logic    w_ready;
    mem_r_t  r;
    logic    r_valid;
    mem_b_t  b;
    logic    b_valid;
  } mem_rsp_t;

  // unknown classes fall back to fetch
  function automatic src_e id_class_of(input logic [ID_W-1:0] id);
    case (id[ID_W-1 -: 2])
      ID_CLASS_BYPASS: return SRC_BYPASS;
      ID_CLASS_DATA:   return SRC_DATA;
      default:         return SRC_FETCH;
    endcase
  endfunction

endpackage

// File: rtl/port_arbiter.sv
// ----------------------------------------------------------------------
// round-robin arbiter for one address channel, grant locked while stalled
// hold_i drops the output valid and all readies for the whole cycle
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module port_arbiter #(
  parameter type payload_t = mem_port_pkg::mem_ar_t
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  payload_t                         req_data_i [mem_port_pkg::NUM_SRC],
  input  logic [mem_port_pkg::NUM_SRC-1:0] req_valid_i,
  output logic [mem_port_pkg::NUM_SRC-1:0] req_ready_o,
  output payload_t                         out_data_o,
  output logic                             out_valid_o,
  input  logic                             out_ready_i,
  input  logic                             hold_i
);
  import mem_port_pkg::*;

  logic [SRC_W-1:0] prio_q;   // first requester looked at
  logic [SRC_W-1:0] grant_q;
  logic             lock_q;
  logic [SRC_W-1:0] rr_idx;
  logic [SRC_W-1:0] grant;
  logic             fire;

  // closest valid requester at or after prio_q wins
  always_comb begin
    int idx;
    rr_idx = prio_q;
    for (int i = NUM_SRC - 1; i >= 0; i--) begin
      idx = int'(prio_q) + i;
      if (idx >= NUM_SRC) begin
        idx = idx - NUM_SRC;
      end
      if (req_valid_i[idx]) begin
        rr_idx = SRC_W'(idx);
      end
    end
  end

  assign grant = lock_q ? grant_q : rr_idx;  // keep payload stable on stall

  always_comb begin
    out_data_o         = req_data_i[grant];
    out_valid_o        = req_valid_i[grant] & ~hold_i;
    req_ready_o        = '0;
    req_ready_o[grant] = out_ready_i & out_valid_o;
  end

  assign fire = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_q  <= SRC_W'(SRC_FETCH);
      grant_q <= SRC_W'(SRC_FETCH);
      lock_q  <= 1'b0;
    end else begin
      lock_q  <= out_valid_o & ~out_ready_i;
      grant_q <= grant;
      if (fire) begin
        // move past the winner
        prio_q <= (grant == SRC_W'(NUM_SRC - 1)) ? '0 : grant + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // assertions
  // ----------------------------------------------------------------------
  // requester must hold valid and payload until accepted
  a_stall_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i) |=>
      (out_valid_o && grant == $past(grant) && $stable(out_data_o))
  ) else $error("arbiter grant or payload changed during a stall");

endmodule

// File: rtl/write_route_ctrl.sv
// ----------------------------------------------------------------------
// records the source of each accepted write address in arrival order
// head becomes visible the cycle after the push, no fall-through
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module write_route_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          aw_fire_i,
  input  logic [mem_port_pkg::ID_W-1:0] aw_id_i,
  input  logic                          w_fire_last_i,
  output mem_port_pkg::src_e            w_sel_o,
  output logic                          full_o
);
  import mem_port_pkg::*;

  src_e               fifo_q [W_FIFO_DEPTH];
  logic [W_PTR_W-1:0] wr_ptr_q;
  logic [W_PTR_W-1:0] rd_ptr_q;
  logic [W_PTR_W:0]   count_q;
  src_e               push_src;
  logic               push;
  logic               pop;
  logic               empty;

  assign push_src = id_class_of(aw_id_i);
  assign push     = aw_fire_i;
  assign pop      = w_fire_last_i;  // burst done
  assign empty    = (count_q == '0);
  assign full_o   = (count_q == (W_PTR_W + 1)'(W_FIFO_DEPTH));

  // fetch never writes so it doubles as "no write selected"
  assign w_sel_o = empty ? SRC_FETCH : fifo_q[rd_ptr_q];

  // ----------------------------------------------------------------------
  // storage and pointers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= push_src;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps, depth is a power of two
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // assertions
  // ----------------------------------------------------------------------
  // aw arbiter must be held off by full_o
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) push |-> !full_o
  ) else $error("write route push while full");

  // w mux must block data with nothing recorded
  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) pop |-> !empty
  ) else $error("write route pop while empty");

  a_no_fetch_push: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) push |-> (push_src != SRC_FETCH)
  ) else $error("write address with fetch ID class %4b", aw_id_i);

endmodule

// File: rtl/write_data_mux.sv
// ----------------------------------------------------------------------
// write data steering by the recorded write source
// fetch selection blocks every write data channel
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module write_data_mux (
  input  mem_port_pkg::src_e               w_sel_i,
  input  mem_port_pkg::mem_w_t             src_w_i [mem_port_pkg::NUM_SRC],
  input  logic [mem_port_pkg::NUM_SRC-1:0] src_w_valid_i,
  output logic [mem_port_pkg::NUM_SRC-1:0] src_w_ready_o,
  output mem_port_pkg::mem_w_t             out_w_o,
  output logic                             out_w_valid_o,
  input  logic                             out_w_ready_i
);
  import mem_port_pkg::*;

  always_comb begin
    out_w_o       = '0;
    out_w_valid_o = 1'b0;
    src_w_ready_o = '0;
    if (w_sel_i != SRC_FETCH) begin
      out_w_o                = src_w_i[w_sel_i];
      out_w_valid_o          = src_w_valid_i[w_sel_i];
      // only the selected source sees ready
      src_w_ready_o[w_sel_i] = out_w_ready_i & src_w_valid_i[w_sel_i];
    end
  end

endmodule

// File: rtl/resp_router.sv
// ----------------------------------------------------------------------
// response demultiplexer, payload goes to all requesters unchanged
// payload_t needs an id field, only the matching class sees valid
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module resp_router #(
  parameter type payload_t = mem_port_pkg::mem_r_t
) (
  input  payload_t                         in_data_i,
  input  logic                             in_valid_i,
  output logic                             in_ready_o,
  output payload_t                         out_data_o [mem_port_pkg::NUM_SRC],
  output logic [mem_port_pkg::NUM_SRC-1:0] out_valid_o,
  input  logic [mem_port_pkg::NUM_SRC-1:0] out_ready_i
);
  import mem_port_pkg::*;

  src_e sel;

  assign sel = id_class_of(in_data_i.id);

  // fan out payload
  always_comb begin
    for (int s = 0; s < NUM_SRC; s++) begin
      out_data_o[s] = in_data_i;
    end
  end

  always_comb begin
    out_valid_o      = '0;
    out_valid_o[sel] = in_valid_i;
  end

  assign in_ready_o = out_ready_i[sel];  // straight from the owner

endmodule

// File: rtl/mem_port_mux.sv
// ----------------------------------------------------------------------
// joins fetch, bypass and data requesters onto one memory port
// at most W_FIFO_DEPTH writes in flight, reads are not limited
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module mem_port_mux (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mem_port_pkg::mem_req_t src_req_i [mem_port_pkg::NUM_SRC],
  output mem_port_pkg::mem_rsp_t src_rsp_o [mem_port_pkg::NUM_SRC],
  output mem_port_pkg::mem_req_t mem_req_o,
  input  mem_port_pkg::mem_rsp_t mem_rsp_i
);
  import mem_port_pkg::*;

  // per requester channel arrays
  mem_ar_t            ar_data [NUM_SRC];
  mem_aw_t            aw_data [NUM_SRC];
  mem_w_t             w_data  [NUM_SRC];
  mem_r_t             r_data  [NUM_SRC];
  mem_b_t             b_data  [NUM_SRC];
  logic [NUM_SRC-1:0] ar_valid, ar_ready;
  logic [NUM_SRC-1:0] aw_valid, aw_ready;
  logic [NUM_SRC-1:0] w_valid, w_ready;
  logic [NUM_SRC-1:0] r_valid, r_ready;
  logic [NUM_SRC-1:0] b_valid, b_ready;

  // memory side
  mem_ar_t mem_ar;
  mem_aw_t mem_aw;
  mem_w_t  mem_w;
  logic    mem_ar_valid;
  logic    mem_aw_valid;
  logic    mem_w_valid;
  logic    mem_r_ready;
  logic    mem_b_ready;

  src_e    w_sel;
  logic    w_fifo_full;
  logic    aw_fire;
  logic    w_fire_last;

  always_comb begin
    for (int s = 0; s < NUM_SRC; s++) begin
      ar_data[s]  = src_req_i[s].ar;
      ar_valid[s] = src_req_i[s].ar_valid;
      aw_data[s]  = src_req_i[s].aw;
      aw_valid[s] = src_req_i[s].aw_valid;
      w_data[s]   = src_req_i[s].w;
      w_valid[s]  = src_req_i[s].w_valid;
      r_ready[s]  = src_req_i[s].r_ready;
      b_ready[s]  = src_req_i[s].b_ready;
    end
  end

  // ----------------------------------------------------------------------
  // address channels
  // ----------------------------------------------------------------------
  port_arbiter #(.payload_t(mem_ar_t)) i_ar_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_data_i  (ar_data),
    .req_valid_i (ar_valid),
    .req_ready_o (ar_ready),
    .out_data_o  (mem_ar),
    .out_valid_o (mem_ar_valid),
    .out_ready_i (mem_rsp_i.ar_ready),
    .hold_i      (1'b0)                 // reads never blocked
  );

  port_arbiter #(.payload_t(mem_aw_t)) i_aw_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_data_i  (aw_data),
    .req_valid_i (aw_valid),
    .req_ready_o (aw_ready),
    .out_data_o  (mem_aw),
    .out_valid_o (mem_aw_valid),
    .out_ready_i (mem_rsp_i.aw_ready),
    .hold_i      (w_fifo_full)
  );

  // ----------------------------------------------------------------------
  // write data
  // ----------------------------------------------------------------------
  assign aw_fire     = mem_aw_valid & mem_rsp_i.aw_ready;
  assign w_fire_last = mem_w_valid & mem_rsp_i.w_ready & mem_w.last;

  write_route_ctrl i_write_route_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .aw_fire_i     (aw_fire),
    .aw_id_i       (mem_aw.id),
    .w_fire_last_i (w_fire_last),
    .w_sel_o       (w_sel),
    .full_o        (w_fifo_full)
  );

  write_data_mux i_write_data_mux (
    .w_sel_i       (w_sel),
    .src_w_i       (w_data),
    .src_w_valid_i (w_valid),
    .src_w_ready_o (w_ready),
    .out_w_o       (mem_w),
    .out_w_valid_o (mem_w_valid),
    .out_w_ready_i (mem_rsp_i.w_ready)
  );

  // ----------------------------------------------------------------------
  // responses routed by ID class
  // ----------------------------------------------------------------------
  resp_router #(.payload_t(mem_r_t)) i_r_router (
    .in_data_i   (mem_rsp_i.r),
    .in_valid_i  (mem_rsp_i.r_valid),
    .in_ready_o  (mem_r_ready),
    .out_data_o  (r_data),
    .out_valid_o (r_valid),
    .out_ready_i (r_ready)
  );

  resp_router #(.payload_t(mem_b_t)) i_b_router (
    .in_data_i   (mem_rsp_i.b),
    .in_valid_i  (mem_rsp_i.b_valid),
    .in_ready_o  (mem_b_ready),
    .out_data_o  (b_data),
    .out_valid_o (b_valid),
    .out_ready_i (b_ready)
  );

  always_comb begin
    mem_req_o.ar       = mem_ar;
    mem_req_o.ar_valid = mem_ar_valid;
    mem_req_o.aw       = mem_aw;
    mem_req_o.aw_valid = mem_aw_valid;
    mem_req_o.w        = mem_w;
    mem_req_o.w_valid  = mem_w_valid;
    mem_req_o.r_ready  = mem_r_ready;
    mem_req_o.b_ready  = mem_b_ready;
  end

  always_comb begin
    for (int s = 0; s < NUM_SRC; s++) begin
      src_rsp_o[s].ar_ready = ar_ready[s];
      src_rsp_o[s].aw_ready = aw_ready[s];
      src_rsp_o[s].w_ready  = w_ready[s];
      src_rsp_o[s].r        = r_data[s];
      src_rsp_o[s].r_valid  = r_valid[s];
      src_rsp_o[s].b        = b_data[s];
      src_rsp_o[s].b_valid  = b_valid[s];
    end
  end

  // ----------------------------------------------------------------------
  // ID classes per requester, routing depends on them
  // ----------------------------------------------------------------------
  a_fetch_arid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    src_req_i[SRC_FETCH].ar_valid |-> (src_req_i[SRC_FETCH].ar.id == ID_FETCH)
  ) else $error("unexpected fetch ARID %4b", src_req_i[SRC_FETCH].ar.id);

  a_fetch_no_aw: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !src_req_i[SRC_FETCH].aw_valid
  ) else $error("fetch raised aw_valid");

  a_bypass_id: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (src_req_i[SRC_BYPASS].ar_valid |-> src_req_i[SRC_BYPASS].ar.id[3:2] == ID_CLASS_BYPASS) and
    (src_req_i[SRC_BYPASS].aw_valid |-> src_req_i[SRC_BYPASS].aw.id[3:2] == ID_CLASS_BYPASS)
  ) else $error("unexpected bypass ID class");

  a_data_id: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (src_req_i[SRC_DATA].ar_valid |-> src_req_i[SRC_DATA].ar.id == ID_DATA) and
    (src_req_i[SRC_DATA].aw_valid |-> src_req_i[SRC_DATA].aw.id == ID_DATA)
  ) else $error("unexpected data ID");

endmodule

// File: tests/tb_mem_port_mux.sv
// ----------------------------------------------------------------------
// three random requesters and an in-order memory model around the mux
// every check is a concurrent assertion, the first failure ends the run
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_mem_port_mux;
  import mem_port_pkg::*;

  localparam int N_RD           = 40;  // reads per requester
  localparam int N_WR           = 20;  // writes per writing requester
  // about 25 cycles for each transaction
  localparam int TIMEOUT_CYCLES = (NUM_SRC * N_RD + 2 * N_WR) * 25;

  logic     clk_i;
  logic     rst_n_i;
  mem_req_t src_req [NUM_SRC];
  mem_rsp_t src_rsp [NUM_SRC];
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  logic [31:0] lfsr_q    = 32'he1179388;
  int          cycle_cnt = 0;
  logic        all_done  = 1'b0;

  // requester bookkeeping
  int          ar_sent [NUM_SRC];
  int          aw_sent [NUM_SRC];
  int          rd_done [NUM_SRC];
  int          wr_done [NUM_SRC];
  int          w_beat  [NUM_SRC];
  logic [7:0]  w_len_q [NUM_SRC][$];  // issued bursts still owing data
  int          w_src_q [$];           // expected write data order
  int          exp_w_count;
  int          exp_w_src;

  // memory model
  mem_ar_t         mem_ar_q    [$];
  logic [ID_W-1:0] mem_aw_id_q [$];
  logic [ID_W-1:0] mem_b_id_q  [$];
  int              r_beat;

  // arbitration history
  int   last_ar_src;
  int   last_aw_src;
  logic last_ar_ok;
  logic last_aw_ok;
  logic ar_stalled_q;
  logic aw_stalled_q;

  mem_port_mux UUT (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .src_req_i (src_req),
    .src_rsp_o (src_rsp),
    .mem_req_o (mem_req),
    .mem_rsp_i (mem_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic next_rand_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], next_rand_bit()};
    end
    return v;
  endfunction

  // requester class from ID bits [3:2]
  function automatic int owner_of_id(input logic [ID_W-1:0] id);
    case (id[3:2])
      2'b10:   return 1;
      2'b11:   return 2;
      default: return 0;
    endcase
  endfunction

  function automatic mem_ar_t make_addr_req(input int s);
    mem_ar_t a;
    a.id   = (s == 0) ? 4'b0000 : (s == 1) ? {2'b10, 2'(rand_bits(2))} : 4'b1100;
    a.addr = {8'h80, rand_bits(16), 8'h00};
    a.len  = 8'(rand_bits(2));
    a.size = 3'd3;
    return a;
  endfunction

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic fail_value(input string name, input logic [127:0] exp,
                            input logic [127:0] act);
    $display("FAILED %s expected %0h actual %0h", name, exp, act);
    abort_run();
  endtask

  task automatic fail_text(input string what);
    $display("%s", what);
    abort_run();
  endtask

  // ----------------------------------------------------------------------
  // expected routing
  // ----------------------------------------------------------------------
  logic [NUM_SRC-1:0] ar_valid_vec;
  logic [NUM_SRC-1:0] aw_valid_vec;
  logic [NUM_SRC-1:0] w_valid_vec;
  logic [NUM_SRC-1:0] ar_ready_vec;
  logic [NUM_SRC-1:0] aw_ready_vec;
  logic [NUM_SRC-1:0] w_ready_vec;
  logic [NUM_SRC-1:0] r_valid_vec;
  logic [NUM_SRC-1:0] b_valid_vec;
  logic [NUM_SRC-1:0] ar_ready_exp;
  logic [NUM_SRC-1:0] aw_ready_exp;
  logic [NUM_SRC-1:0] w_ready_exp;
  logic [NUM_SRC-1:0] r_valid_exp;
  logic [NUM_SRC-1:0] b_valid_exp;
  mem_ar_t            ar_src_payload;
  mem_aw_t            aw_src_payload;
  mem_w_t             w_src_payload;
  mem_r_t             r_owner_payload;
  mem_b_t             b_owner_payload;
  logic               r_ready_exp;
  logic               b_ready_exp;
  logic               ar_repeat;
  logic               aw_repeat;
  logic               ar_rival;
  logic               aw_rival;
  logic               idle_in;

  always_comb begin
    for (int s = 0; s < NUM_SRC; s++) begin
      ar_valid_vec[s] = src_req[s].ar_valid;
      aw_valid_vec[s] = src_req[s].aw_valid;
      w_valid_vec[s]  = src_req[s].w_valid;
      ar_ready_vec[s] = src_rsp[s].ar_ready;
      aw_ready_vec[s] = src_rsp[s].aw_ready;
      w_ready_vec[s]  = src_rsp[s].w_ready;
      r_valid_vec[s]  = src_rsp[s].r_valid;
      b_valid_vec[s]  = src_rsp[s].b_valid;
    end
    ar_src_payload  = src_req[owner_of_id(mem_req.ar.id)].ar;
    aw_src_payload  = src_req[owner_of_id(mem_req.aw.id)].aw;
    w_src_payload   = src_req[exp_w_src].w;
    r_owner_payload = src_rsp[owner_of_id(mem_rsp.r.id)].r;
    b_owner_payload = src_rsp[owner_of_id(mem_rsp.b.id)].b;
    r_ready_exp     = src_req[owner_of_id(mem_rsp.r.id)].r_ready;
    b_ready_exp     = src_req[owner_of_id(mem_rsp.b.id)].b_ready;
    ar_ready_exp   = (mem_req.ar_valid && mem_rsp.ar_ready) ?
                     NUM_SRC'(1) << owner_of_id(mem_req.ar.id) : '0;
    aw_ready_exp   = (mem_req.aw_valid && mem_rsp.aw_ready) ?
                     NUM_SRC'(1) << owner_of_id(mem_req.aw.id) : '0;
    w_ready_exp    = (mem_req.w_valid && mem_rsp.w_ready) ? NUM_SRC'(1) << exp_w_src : '0;
    r_valid_exp    = mem_rsp.r_valid ? NUM_SRC'(1) << owner_of_id(mem_rsp.r.id) : '0;
    b_valid_exp    = mem_rsp.b_valid ? NUM_SRC'(1) << owner_of_id(mem_rsp.b.id) : '0;
    // a fresh grant decision that picks the last winner again
    ar_repeat = mem_req.ar_valid && !ar_stalled_q && last_ar_ok &&
                owner_of_id(mem_req.ar.id) == last_ar_src;
    aw_repeat = mem_req.aw_valid && !aw_stalled_q && last_aw_ok &&
                owner_of_id(mem_req.aw.id) == last_aw_src;
    ar_rival  = |(ar_valid_vec & ~(NUM_SRC'(1) << owner_of_id(mem_req.ar.id)));
    aw_rival  = |(aw_valid_vec & ~(NUM_SRC'(1) << owner_of_id(mem_req.aw.id)));
    idle_in   = !(|ar_valid_vec) && !(|aw_valid_vec) && !(|w_valid_vec) &&
                !mem_rsp.r_valid && !mem_rsp.b_valid;
  end

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  a_ar_payload: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req.ar_valid |-> mem_req.ar == ar_src_payload)
    else fail_value("ar_payload", $sampled(ar_src_payload), $sampled(mem_req.ar));
  a_aw_payload: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req.aw_valid |-> mem_req.aw == aw_src_payload)
    else fail_value("aw_payload", $sampled(aw_src_payload), $sampled(mem_req.aw));
  a_ar_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ar_ready_vec == ar_ready_exp)
    else fail_value("ar_ready_route", $sampled(ar_ready_exp), $sampled(ar_ready_vec));
  a_aw_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aw_ready_vec == aw_ready_exp)
    else fail_value("aw_ready_route", $sampled(aw_ready_exp), $sampled(aw_ready_vec));
  a_ar_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_req.ar_valid && !mem_rsp.ar_ready) |=> (mem_req.ar_valid && $stable(mem_req.ar)))
    else fail_text("memory ar dropped or changed while stalled");
  a_aw_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_req.aw_valid && !mem_rsp.aw_ready) |=> (mem_req.aw_valid && $stable(mem_req.aw)))
    else fail_text("memory aw dropped or changed while stalled");
  a_ar_fair: assert property (@(posedge clk_i) disable iff (!rst_n_i) ar_repeat |-> !ar_rival)
    else fail_text("ar granted the last winner again while another requester waited");
  a_aw_fair: assert property (@(posedge clk_i) disable iff (!rst_n_i) aw_repeat |-> !aw_rival)
    else fail_text("aw granted the last winner again while another requester waited");
  a_w_after_aw: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req.w_valid |-> exp_w_count > 0)
    else fail_text("write data forwarded before its write address was accepted");
  a_w_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    w_ready_vec == w_ready_exp)
    else fail_value("w_source_order", $sampled(w_ready_exp), $sampled(w_ready_vec));
  a_w_payload: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req.w_valid |-> mem_req.w == w_src_payload)
    else fail_value("w_payload", $sampled(w_src_payload), $sampled(mem_req.w));
  a_r_route: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_vec == r_valid_exp && (mem_rsp.r_valid -> mem_req.r_ready == r_ready_exp))
    else fail_value("r_route", {$sampled(r_valid_exp), $sampled(r_ready_exp)},
                    {$sampled(r_valid_vec), $sampled(mem_req.r_ready)});
  a_b_route: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_valid_vec == b_valid_exp && (mem_rsp.b_valid -> mem_req.b_ready == b_ready_exp))
    else fail_value("b_route", {$sampled(b_valid_exp), $sampled(b_ready_exp)},
                    {$sampled(b_valid_vec), $sampled(mem_req.b_ready)});
  a_r_payload: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rsp.r_valid |-> r_owner_payload == mem_rsp.r)
    else fail_value("r_payload", $sampled(mem_rsp.r), $sampled(r_owner_payload));
  a_b_payload: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rsp.b_valid |-> b_owner_payload == mem_rsp.b)
    else fail_value("b_payload", $sampled(mem_rsp.b), $sampled(b_owner_payload));
  a_aw_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exp_w_count == W_FIFO_DEPTH |-> !mem_req.aw_valid)
    else fail_value("aw_hold_when_full", 0, $sampled(mem_req.aw_valid));
  a_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    idle_in |-> !(mem_req.ar_valid || mem_req.aw_valid || mem_req.w_valid ||
                  |r_valid_vec || |b_valid_vec))
    else fail_value("idle_valids", 0, $sampled({mem_req.ar_valid, mem_req.aw_valid,
                    mem_req.w_valid, |r_valid_vec, |b_valid_vec}));

  // ----------------------------------------------------------------------
  // requesters and memory model
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin
    logic [NUM_SRC-1:0] ar_acc;
    logic [NUM_SRC-1:0] aw_acc;
    logic [NUM_SRC-1:0] w_acc;
    logic               r_fire;
    logic               b_fire;
    logic               traffic_on;
    logic               w_pause;
    if (rst_n_i) begin
      // handshakes of this edge
      for (int s = 0; s < NUM_SRC; s++) begin
        ar_acc[s] = src_req[s].ar_valid && src_rsp[s].ar_ready;
        aw_acc[s] = src_req[s].aw_valid && src_rsp[s].aw_ready;
        w_acc[s]  = src_req[s].w_valid && src_rsp[s].w_ready;
        if (src_rsp[s].r_valid && src_req[s].r_ready && src_rsp[s].r.last) begin
          rd_done[s]++;
        end
        if (src_rsp[s].b_valid && src_req[s].b_ready) begin
          wr_done[s]++;
        end
        if (aw_acc[s]) begin
          w_src_q.push_back(s);
        end
        if (w_acc[s] && src_req[s].w.last) begin
          void'(w_len_q[s].pop_front());
          w_beat[s] = 0;
        end else if (w_acc[s]) begin
          w_beat[s]++;
        end
      end
      r_fire = mem_rsp.r_valid && mem_req.r_ready;
      b_fire = mem_rsp.b_valid && mem_req.b_ready;
      if (mem_req.ar_valid && mem_rsp.ar_ready) begin
        mem_ar_q.push_back(mem_req.ar);
        last_ar_src = owner_of_id(mem_req.ar.id);
        last_ar_ok  = 1'b1;
      end
      if (mem_req.aw_valid && mem_rsp.aw_ready) begin
        mem_aw_id_q.push_back(mem_req.aw.id);
        last_aw_src = owner_of_id(mem_req.aw.id);
        last_aw_ok  = 1'b1;
      end
      ar_stalled_q = mem_req.ar_valid && !mem_rsp.ar_ready;
      aw_stalled_q = mem_req.aw_valid && !mem_rsp.aw_ready;
      if (mem_req.w_valid && mem_rsp.w_ready && mem_req.w.last && w_src_q.size() > 0) begin
        void'(w_src_q.pop_front());
        mem_b_id_q.push_back(mem_aw_id_q.pop_front());
      end
      if (r_fire && mem_rsp.r.last) begin
        void'(mem_ar_q.pop_front());
        r_beat = 0;
      end else if (r_fire) begin
        r_beat++;
      end
      if (b_fire) begin
        void'(mem_b_id_q.pop_front());
      end
      exp_w_count = w_src_q.size();
      exp_w_src   = (w_src_q.size() > 0) ? w_src_q[0] : 0;
      all_done    = 1'b1;
      for (int s = 0; s < NUM_SRC; s++) begin
        if (rd_done[s] != N_RD || wr_done[s] != ((s == 0) ? 0 : N_WR)) begin
          all_done = 1'b0;
        end
      end

      #1;
      traffic_on = cycle_cnt >= 10;
      w_pause    = cycle_cnt >= 40 && cycle_cnt < 240;  // lets the write FIFO fill
      for (int s = 0; s < NUM_SRC; s++) begin
        if (ar_acc[s]) src_req[s].ar_valid = 1'b0;
        if (aw_acc[s]) src_req[s].aw_valid = 1'b0;
        if (w_acc[s])  src_req[s].w_valid  = 1'b0;
        if (!src_req[s].ar_valid && traffic_on && ar_sent[s] < N_RD && next_rand_bit()) begin
          src_req[s].ar       = make_addr_req(s);
          src_req[s].ar_valid = 1'b1;
          ar_sent[s]++;
        end
        // fetch never writes
        if (s != 0 && !src_req[s].aw_valid && traffic_on && aw_sent[s] < N_WR &&
            next_rand_bit()) begin
          src_req[s].aw       = mem_aw_t'(make_addr_req(s));
          src_req[s].aw_valid = 1'b1;
          aw_sent[s]++;
          // data may be offered before the address is taken
          w_len_q[s].push_back(src_req[s].aw.len);
        end
        if (!src_req[s].w_valid && w_len_q[s].size() > 0 && !w_pause && next_rand_bit()) begin
          src_req[s].w.data  = {rand_bits(16), rand_bits(16), rand_bits(16), rand_bits(16)};
          src_req[s].w.strb  = 8'hff;
          src_req[s].w.last  = (w_beat[s] == int'(w_len_q[s][0]));
          src_req[s].w_valid = 1'b1;
        end
        src_req[s].r_ready = next_rand_bit() | next_rand_bit();
        src_req[s].b_ready = next_rand_bit() | next_rand_bit();
      end
      mem_rsp.ar_ready = next_rand_bit();
      mem_rsp.aw_ready = next_rand_bit();
      mem_rsp.w_ready  = next_rand_bit();
      if (r_fire) mem_rsp.r_valid = 1'b0;
      if (b_fire) mem_rsp.b_valid = 1'b0;
      if (!mem_rsp.r_valid && mem_ar_q.size() > 0 && next_rand_bit()) begin
        mem_rsp.r.id    = mem_ar_q[0].id;
        mem_rsp.r.data  = {rand_bits(16), rand_bits(16), rand_bits(16), rand_bits(16)};
        mem_rsp.r.resp  = 2'b00;
        mem_rsp.r.last  = (r_beat == int'(mem_ar_q[0].len));
        mem_rsp.r_valid = 1'b1;
      end
      if (!mem_rsp.b_valid && mem_b_id_q.size() > 0 && next_rand_bit()) begin
        mem_rsp.b.id    = mem_b_id_q[0];
        mem_rsp.b.resp  = 2'b00;
        mem_rsp.b_valid = 1'b1;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      fail_text("timeout: traffic did not complete within the cycle limit");
    end
  end

  initial begin
    rst_n_i = 1'b0;
    mem_rsp = '0;
    for (int s = 0; s < NUM_SRC; s++) begin
      src_req[s] = '0;
      ar_sent[s] = 0;
      aw_sent[s] = 0;
      rd_done[s] = 0;
      wr_done[s] = 0;
      w_beat[s]  = 0;
    end
    exp_w_count  = 0;
    exp_w_src    = 0;
    r_beat       = 0;
    last_ar_src  = 0;
    last_aw_src  = 0;
    last_ar_ok   = 1'b0;
    last_aw_ok   = 1'b0;
    ar_stalled_q = 1'b0;
    aw_stalled_q = 1'b0;
    repeat (3) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    // idle stretch after reset, then random traffic until all done
    while (!all_done) @(posedge clk_i);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: mem_port_mux.f
rtl/mem_port_pkg.sv
rtl/port_arbiter.sv
rtl/write_route_ctrl.sv
rtl/write_data_mux.sv
rtl/resp_router.sv
rtl/mem_port_mux.sv
tests/tb_mem_port_mux.sv

// File: Bender.yml
package:
  name: mem_port_mux

sources:
  # package first, then leaf modules, then the top level
  - files:
      - rtl/mem_port_pkg.sv
      - rtl/port_arbiter.sv
      - rtl/write_route_ctrl.sv
      - rtl/write_data_mux.sv
      - rtl/resp_router.sv
      - rtl/mem_port_mux.sv

  # testbench, top module tb_mem_port_mux
  - target: test
    files:
      - tests/tb_mem_port_mux.sv
